//--- rtl/mpsoc_pkg.sv
package mpsoc_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////////////////////////
  localparam int ADDR_W   = 32;
  localparam int DATA_W   = 32;
  localparam int SEL_W    = 4;

  // Tile field caps the fabric at 256 tiles
  localparam int TILE_W   = 8;
  localparam int OFFSET_W = 22;

  //////////////////////////////////////////////////////////////////////
  // In-tile regions and mailbox map
  //////////////////////////////////////////////////////////////////////
  localparam logic REGION_MEM  = 1'b0;
  localparam logic REGION_MBOX = 1'b1;

  // Word offsets inside the mailbox region
  localparam logic [OFFSET_W-1:0] MBOX_DATA = 22'd0;
  localparam logic [OFFSET_W-1:0] MBOX_IER  = 22'd1;
  localparam logic [OFFSET_W-1:0] MBOX_STAT = 22'd2;

  //////////////////////////////////////////////////////////////////////
  // Host address
  //////////////////////////////////////////////////////////////////////
  // Raw word for tracing, field view for decode
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    struct packed {
      logic [TILE_W-1:0]   tile;
      logic                spare;
      logic                region;
      logic [OFFSET_W-1:0] offset;
    } f;
  } host_addr_u;

endpackage

//--- rtl/mpsoc_dbg_dispatch.sv
module mpsoc_dbg_dispatch #(
  parameter int NUM_TILES = 4
) (
  input  logic                           wb_clk_i,
  input  logic                           rst_i,
  input  logic                           req_i,
  input  logic                           we_i,
  input  mpsoc_pkg::host_addr_u          addr_i,
  input  logic [mpsoc_pkg::DATA_W-1:0]   wdata_i,
  input  logic [mpsoc_pkg::SEL_W-1:0]    sel_i,
  output logic [NUM_TILES-1:0]           tile_stb_o,
  output logic                           tile_we_o,
  output logic                           tile_region_o,
  output logic [mpsoc_pkg::OFFSET_W-1:0] tile_offset_o,
  output logic [mpsoc_pkg::DATA_W-1:0]   tile_wdata_o,
  output logic [mpsoc_pkg::SEL_W-1:0]    tile_sel_o,
  output logic                           dec_err_o
);
  import mpsoc_pkg::*;

  logic [NUM_TILES-1:0] stb_d;
  logic                 tile_hit;
  host_addr_u           addr_q;

  // One-hot tile select from the tile field
  always_comb begin
    for (int t = 0; t < NUM_TILES; t++) begin
      stb_d[t] = req_i && (int'(addr_i.f.tile) == t);
    end
  end

  // No strobe means the tile number is out of range
  assign tile_hit = |stb_d;

  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      tile_stb_o <= '0;
      dec_err_o  <= 1'b0;
    end else begin
      tile_stb_o <= stb_d;
      dec_err_o  <= req_i && !tile_hit;
    end
  end

  // Request payload, address kept as a raw word
  always_ff @(posedge wb_clk_i) begin
    if (req_i) begin
      addr_q.raw   <= addr_i.raw;
      tile_we_o    <= we_i;
      tile_wdata_o <= wdata_i;
      tile_sel_o   <= sel_i;
    end
  end

  // Shared fields fan out to every tile
  assign tile_region_o = addr_q.f.region;
  assign tile_offset_o = addr_q.f.offset;

endmodule

//--- rtl/mpsoc_tile_ram.sv
module mpsoc_tile_ram #(
  parameter int MEM_WORDS = 256
) (
  input  logic                           wb_clk_i,
  input  logic                           rst_i,
  input  logic                           stb_i,
  input  logic                           we_i,
  input  logic [mpsoc_pkg::OFFSET_W-1:0] offset_i,
  input  logic [mpsoc_pkg::DATA_W-1:0]   wdata_i,
  input  logic [mpsoc_pkg::SEL_W-1:0]    sel_i,
  output logic [mpsoc_pkg::DATA_W-1:0]   rdata_o,
  output logic                           ack_o
);
  import mpsoc_pkg::*;

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  logic [DATA_W-1:0] mem [MEM_WORDS];
  logic [IDX_W-1:0]  word_idx;
  logic [DATA_W-1:0] rdata_q;
  logic              ack_q;

  // Upper offset bits are ignored, so accesses wrap
  assign word_idx = offset_i[IDX_W-1:0];

  always_ff @(posedge wb_clk_i) begin
    if (stb_i && we_i) begin
      for (int b = 0; b < SEL_W; b++) begin
        if (sel_i[b]) begin
          mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Read word, zero on a write
  always_ff @(posedge wb_clk_i) begin
    if (stb_i) begin
      rdata_q <= we_i ? '0 : mem[word_idx];
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= stb_i;
    end
  end

  assign ack_o   = ack_q;
  assign rdata_o = ack_q ? rdata_q : '0;

endmodule

//--- rtl/mpsoc_tile_mailbox.sv
module mpsoc_tile_mailbox (
  input  logic                           wb_clk_i,
  input  logic                           rst_i,
  input  logic                           stb_i,
  input  logic                           we_i,
  input  logic [mpsoc_pkg::OFFSET_W-1:0] offset_i,
  input  logic [mpsoc_pkg::DATA_W-1:0]   wdata_i,
  output logic [mpsoc_pkg::DATA_W-1:0]   rdata_o,
  output logic                           ack_o,
  output logic                           irq_o
);
  import mpsoc_pkg::*;

  logic [7:0]        data_q;
  logic              pending_q;
  logic              ier_q;
  logic [DATA_W-1:0] rdata_q;
  logic              ack_q;

  //////////////////////////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      data_q    <= '0;
      pending_q <= 1'b0;
      ier_q     <= 1'b0;
    end else if (stb_i && we_i) begin
      case (offset_i)
        MBOX_DATA: begin
          data_q    <= wdata_i[7:0];
          pending_q <= 1'b1;
        end
        MBOX_IER: ier_q <= wdata_i[0];
        default: ;
      endcase
    end else if (stb_i && (offset_i == MBOX_DATA)) begin
      // Reading the byte consumes it
      pending_q <= 1'b0;
    end
  end

  // Read mux
  always_ff @(posedge wb_clk_i) begin
    if (stb_i) begin
      rdata_q <= '0;
      if (!we_i) begin
        case (offset_i)
          MBOX_DATA: rdata_q[7:0] <= data_q;
          MBOX_IER:  rdata_q[0]   <= ier_q;
          MBOX_STAT: rdata_q[0]   <= pending_q;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= stb_i;
    end
  end

  assign ack_o   = ack_q;
  assign rdata_o = ack_q ? rdata_q : '0;
  assign irq_o   = pending_q & ier_q;

endmodule

//--- rtl/mpsoc_tile.sv
module mpsoc_tile #(
  parameter int MEM_WORDS = 256
) (
  input  logic                           wb_clk_i,
  input  logic                           rst_i,
  input  logic                           stb_i,
  input  logic                           we_i,
  input  logic                           region_i,
  input  logic [mpsoc_pkg::OFFSET_W-1:0] offset_i,
  input  logic [mpsoc_pkg::DATA_W-1:0]   wdata_i,
  input  logic [mpsoc_pkg::SEL_W-1:0]    sel_i,
  output logic [mpsoc_pkg::DATA_W-1:0]   rdata_o,
  output logic                           ack_o,
  output logic                           irq_o
);
  import mpsoc_pkg::*;

  logic              mem_stb;
  logic              mbox_stb;
  logic [DATA_W-1:0] mem_rdata;
  logic [DATA_W-1:0] mbox_rdata;
  logic              mem_ack;
  logic              mbox_ack;
  logic              mbox_irq;

  //////////////////////////////////////////////////////////////////////
  // Local bus decode
  //////////////////////////////////////////////////////////////////////
  assign mem_stb  = stb_i && (region_i == REGION_MEM);
  assign mbox_stb = stb_i && (region_i == REGION_MBOX);

  mpsoc_tile_ram #(
    .MEM_WORDS (MEM_WORDS)
  ) u_ram (
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .stb_i    (mem_stb),
    .we_i     (we_i),
    .offset_i (offset_i),
    .wdata_i  (wdata_i),
    .sel_i    (sel_i),
    .rdata_o  (mem_rdata),
    .ack_o    (mem_ack)
  );

  // Stands in for the per-tile serial port
  mpsoc_tile_mailbox u_mbox (
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .stb_i    (mbox_stb),
    .we_i     (we_i),
    .offset_i (offset_i),
    .wdata_i  (wdata_i),
    .rdata_o  (mbox_rdata),
    .ack_o    (mbox_ack),
    .irq_o    (mbox_irq)
  );

  //////////////////////////////////////////////////////////////////////
  // Response merge
  //////////////////////////////////////////////////////////////////////
  // Both targets zero their data when idle
  assign rdata_o = mem_rdata | mbox_rdata;
  assign ack_o   = mem_ack | mbox_ack;
  assign irq_o   = mbox_irq;

endmodule

//--- rtl/mpsoc_resp_collect.sv
module mpsoc_resp_collect #(
  parameter int NUM_TILES = 4
) (
  input  logic                                        wb_clk_i,
  input  logic                                        rst_i,
  input  logic [NUM_TILES-1:0]                        tile_ack_i,
  input  logic [NUM_TILES-1:0][mpsoc_pkg::DATA_W-1:0] tile_rdata_i,
  input  logic [NUM_TILES-1:0]                        tile_irq_i,
  input  logic                                        dec_err_i,
  output logic                                        ack_o,
  output logic [mpsoc_pkg::DATA_W-1:0]                rdata_o,
  output logic                                        err_o,
  output logic [NUM_TILES-1:0]                        irq_o
);
  import mpsoc_pkg::*;

  logic              dec_err_q;
  logic [DATA_W-1:0] rdata_or;

  // At most one tile answers per cycle
  always_comb begin
    rdata_or = '0;
    for (int t = 0; t < NUM_TILES; t++) begin
      rdata_or = rdata_or | tile_rdata_i[t];
    end
  end

  // Error path has no tile stage, so it waits one cycle here
  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      dec_err_q <= 1'b0;
    end else begin
      dec_err_q <= dec_err_i;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      ack_o <= 1'b0;
      err_o <= 1'b0;
      irq_o <= '0;
    end else begin
      ack_o <= (|tile_ack_i) | dec_err_q;
      err_o <= dec_err_q;
      irq_o <= tile_irq_i;
    end
  end

  // Zero on an error since no tile acked
  always_ff @(posedge wb_clk_i) begin
    rdata_o <= rdata_or;
  end

endmodule

//--- rtl/mpsoc_top.sv
module mpsoc_top #(
  parameter int NUM_TILES = 4,
  parameter int MEM_WORDS = 256
) (
  input  logic                         wb_clk_i,
  input  logic                         rst_i,
  input  logic                         req_i,
  input  logic                         we_i,
  input  mpsoc_pkg::host_addr_u        addr_i,
  input  logic [mpsoc_pkg::DATA_W-1:0] wdata_i,
  input  logic [mpsoc_pkg::SEL_W-1:0]  sel_i,
  output logic                         ack_o,
  output logic [mpsoc_pkg::DATA_W-1:0] rdata_o,
  output logic                         err_o,
  output logic [NUM_TILES-1:0]         irq_o
);
  import mpsoc_pkg::*;

  logic [NUM_TILES-1:0]             tile_stb;
  logic                             tile_we;
  logic                             tile_region;
  logic [OFFSET_W-1:0]              tile_offset;
  logic [DATA_W-1:0]                tile_wdata;
  logic [SEL_W-1:0]                 tile_sel;
  logic                             dec_err;
  logic [NUM_TILES-1:0]             tile_ack;
  logic [NUM_TILES-1:0][DATA_W-1:0] tile_rdata;
  logic [NUM_TILES-1:0]             tile_irq;

  //////////////////////////////////////////////////////////////////////
  // Debug access dispatch
  //////////////////////////////////////////////////////////////////////
  mpsoc_dbg_dispatch #(
    .NUM_TILES (NUM_TILES)
  ) u_dispatch (
    .wb_clk_i      (wb_clk_i),
    .rst_i         (rst_i),
    .req_i         (req_i),
    .we_i          (we_i),
    .addr_i        (addr_i),
    .wdata_i       (wdata_i),
    .sel_i         (sel_i),
    .tile_stb_o    (tile_stb),
    .tile_we_o     (tile_we),
    .tile_region_o (tile_region),
    .tile_offset_o (tile_offset),
    .tile_wdata_o  (tile_wdata),
    .tile_sel_o    (tile_sel),
    .dec_err_o     (dec_err)
  );

  //////////////////////////////////////////////////////////////////////
  // Tile array
  //////////////////////////////////////////////////////////////////////
  for (genvar t = 0; t < NUM_TILES; t++) begin : g_tile
    mpsoc_tile #(
      .MEM_WORDS (MEM_WORDS)
    ) u_tile (
      .wb_clk_i (wb_clk_i),
      .rst_i    (rst_i),
      .stb_i    (tile_stb[t]),
      .we_i     (tile_we),
      .region_i (tile_region),
      .offset_i (tile_offset),
      .wdata_i  (tile_wdata),
      .sel_i    (tile_sel),
      .rdata_o  (tile_rdata[t]),
      .ack_o    (tile_ack[t]),
      .irq_o    (tile_irq[t])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // Host response
  //////////////////////////////////////////////////////////////////////
  mpsoc_resp_collect #(
    .NUM_TILES (NUM_TILES)
  ) u_collect (
    .wb_clk_i     (wb_clk_i),
    .rst_i        (rst_i),
    .tile_ack_i   (tile_ack),
    .tile_rdata_i (tile_rdata),
    .tile_irq_i   (tile_irq),
    .dec_err_i    (dec_err),
    .ack_o        (ack_o),
    .rdata_o      (rdata_o),
    .err_o        (err_o),
    .irq_o        (irq_o)
  );

endmodule

//--- tests/tb_mpsoc_tasks.svh
`ifndef TB_MPSOC_TASKS_SVH
`define TB_MPSOC_TASKS_SVH

// Single access with the ack due on the third rising edge
task automatic do_access(input string name, input logic wr, input logic [7:0] tile,
                         input logic region, input logic [OFFSET_W-1:0] offset,
                         input logic [31:0] wd, input logic [3:0] be,
                         output logic [31:0] rd, output logic er);
  int cycles;
  cycles = 0;
  @(negedge wb_clk);
  req      = 1'b1;
  we       = wr;
  addr.raw = make_addr(tile, region, offset);
  wdata    = wd;
  sel      = be;
  do begin
    @(negedge wb_clk);
    req = 1'b0;
    cycles++;
  end while (!ack && cycles < ACK_LIMIT);
  rd = rdata;
  er = err;
  if (!ack) begin
    $display("%s: no acknowledge within %0d cycles", name, ACK_LIMIT);
    timeout_count++;
  end else if (cycles != 3) begin
    report_mismatch({name, " latency"}, 3, cycles);
  end
endtask

task automatic wait_irq(input string name, input logic [N_TILES-1:0] exp);
  int cycles;
  cycles = 0;
  while (irq !== exp && cycles < ACK_LIMIT) begin
    @(negedge wb_clk);
    cycles++;
  end
  if (irq !== exp) report_mismatch(name, 32'(exp), 32'(irq));
endtask

task automatic test_reset();
  if (ack !== 1'b0) report_mismatch("reset ack_o", 0, 32'(ack));
  if (err !== 1'b0) report_mismatch("reset err_o", 0, 32'(err));
  if (irq !== '0) report_mismatch("reset irq_o", 0, 32'(irq));
endtask

task automatic test_ram_isolation();
  logic [31:0] rd;
  logic        er;
  for (int t = 0; t < N_TILES; t++) begin
    ram_words[t] = rand_bits(32);
    do_access("ram write", 1'b1, 8'(t), REGION_MEM, RAM_OFS, ram_words[t], 4'hF, rd, er);
    if (er !== 1'b0) report_mismatch("ram isolation write err_o", 0, 32'(er));
  end
  for (int t = 0; t < N_TILES; t++) begin
    do_access("ram read", 1'b0, 8'(t), REGION_MEM, RAM_OFS, '0, 4'hF, rd, er);
    if (rd !== ram_words[t]) report_mismatch("ram isolation data", ram_words[t], rd);
    if (er !== 1'b0) report_mismatch("ram isolation err_o", 0, 32'(er));
  end
endtask

task automatic test_byte_select();
  logic [31:0] old_w;
  logic [31:0] new_w;
  logic [31:0] rd;
  logic        er;
  old_w = rand_bits(32);
  new_w = rand_bits(32);
  do_access("byte sel full", 1'b1, 8'd1, REGION_MEM, 22'd9, old_w, 4'hF, rd, er);
  do_access("byte sel part", 1'b1, 8'd1, REGION_MEM, 22'd9, new_w, 4'b0100, rd, er);
  do_access("byte sel read", 1'b0, 8'd1, REGION_MEM, 22'd9, '0, 4'hF, rd, er);
  if (rd !== {old_w[31:24], new_w[23:16], old_w[15:0]}) begin
    report_mismatch("byte select", {old_w[31:24], new_w[23:16], old_w[15:0]}, rd);
  end
endtask

task automatic test_mailbox();
  logic [31:0] wd;
  logic [31:0] rd;
  logic        er;
  wd = rand_bits(32);
  do_access("mbox ier on", 1'b1, 8'd2, REGION_MBOX, MBOX_IER, 32'd1, 4'hF, rd, er);
  do_access("mbox data", 1'b1, 8'd2, REGION_MBOX, MBOX_DATA, wd, 4'hF, rd, er);
  wait_irq("mailbox irq set", 4'b0100);
  do_access("mbox stat", 1'b0, 8'd2, REGION_MBOX, MBOX_STAT, '0, 4'hF, rd, er);
  if (rd !== 32'd1) report_mismatch("mailbox stat", 1, rd);
  do_access("mbox read", 1'b0, 8'd2, REGION_MBOX, MBOX_DATA, '0, 4'hF, rd, er);
  if (rd !== {24'd0, wd[7:0]}) report_mismatch("mailbox data", {24'd0, wd[7:0]}, rd);
  wait_irq("mailbox irq clear", 4'b0000);

  // Pending without enable must stay quiet
  do_access("mbox ier off", 1'b1, 8'd2, REGION_MBOX, MBOX_IER, 32'd0, 4'hF, rd, er);
  do_access("mbox data", 1'b1, 8'd2, REGION_MBOX, MBOX_DATA, wd, 4'hF, rd, er);
  @(negedge wb_clk);
  if (irq !== '0) report_mismatch("mailbox irq masked", 0, 32'(irq));
  do_access("mbox stat", 1'b0, 8'd2, REGION_MBOX, MBOX_STAT, '0, 4'hF, rd, er);
  if (rd !== 32'd1) report_mismatch("mailbox stat masked", 1, rd);
  do_access("mbox read", 1'b0, 8'd2, REGION_MBOX, MBOX_DATA, '0, 4'hF, rd, er);
endtask

task automatic test_decode_error();
  logic [31:0] rd;
  logic        er;
  do_access("dec err write", 1'b1, 8'd7, REGION_MEM, RAM_OFS, rand_bits(32), 4'hF, rd, er);
  if (er !== 1'b1) report_mismatch("decode error err_o", 1, 32'(er));
  if (rd !== '0) report_mismatch("decode error rdata_o", 0, rd);
  do_access("dec err read", 1'b0, 8'd7, REGION_MEM, RAM_OFS, '0, 4'hF, rd, er);
  if (er !== 1'b1) report_mismatch("decode error read err_o", 1, 32'(er));
  if (rd !== '0) report_mismatch("decode error read rdata_o", 0, rd);
  for (int t = 0; t < N_TILES; t++) begin
    do_access("ram recheck", 1'b0, 8'(t), REGION_MEM, RAM_OFS, '0, 4'hF, rd, er);
    if (rd !== ram_words[t]) report_mismatch("decode error ram intact", ram_words[t], rd);
  end
endtask

// Request k goes out at cycle k and its ack is due at cycle k+3
task automatic test_pipeline();
  int order [4];
  int sent;
  int rcvd;
  int cyc;
  order = '{3, 0, 2, 1};
  sent  = 0;
  rcvd  = 0;
  cyc   = 0;
  @(negedge wb_clk);
  while (rcvd < 4 && cyc < ACK_LIMIT) begin
    if (ack) begin
      if (cyc != rcvd + 3) report_mismatch("pipeline latency", 32'(rcvd + 3), 32'(cyc));
      if (rdata !== ram_words[order[rcvd]]) begin
        report_mismatch("pipeline data", ram_words[order[rcvd]], rdata);
      end
      if (err !== 1'b0) report_mismatch("pipeline err_o", 0, 32'(err));
      rcvd++;
    end
    if (sent < 4) begin
      req      = 1'b1;
      we       = 1'b0;
      addr.raw = make_addr(8'(order[sent]), REGION_MEM, RAM_OFS);
      sel      = 4'hF;
      sent++;
    end else begin
      req = 1'b0;
    end
    @(negedge wb_clk);
    cyc++;
  end
  req = 1'b0;
  if (rcvd < 4) begin
    $display("pipeline: only %0d of 4 acknowledges arrived", rcvd);
    timeout_count++;
  end
endtask

`endif

//--- tests/tb_mpsoc.sv
module tb_mpsoc;
  timeunit 1ns;
  timeprecision 1ps;
  import mpsoc_pkg::*;

  localparam int N_TILES   = 4;
  localparam int ACK_LIMIT = 16;
  localparam logic [31:0]         LFSR_TAPS = 32'hB4BC_D35C;
  localparam logic [OFFSET_W-1:0] RAM_OFS   = 22'd5;

  logic               wb_clk;
  logic               rst;
  logic               req;
  logic               we;
  host_addr_u         addr;
  logic [DATA_W-1:0]  wdata;
  logic [SEL_W-1:0]   sel;
  logic               ack;
  logic [DATA_W-1:0]  rdata;
  logic               err;
  logic [N_TILES-1:0] irq;

  logic [31:0] lfsr_state;
  logic [31:0] ram_words [N_TILES];
  int          error_count;
  int          timeout_count;

  mpsoc_top #(
    .NUM_TILES (N_TILES),
    .MEM_WORDS (256)
  ) DUT (
    .wb_clk_i (wb_clk),
    .rst_i    (rst),
    .req_i    (req),
    .we_i     (we),
    .addr_i   (addr),
    .wdata_i  (wdata),
    .sel_i    (sel),
    .ack_o    (ack),
    .rdata_o  (rdata),
    .err_o    (err),
    .irq_o    (irq)
  );

  initial begin
    wb_clk = 1'b0;
    forever #2 wb_clk = ~wb_clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ LFSR_TAPS;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[30:0], lfsr_state[0]};
    end
    return w;
  endfunction

  // Tile, spare bit, region, word offset
  function automatic logic [31:0] make_addr(input logic [7:0] tile, input logic region,
                                            input logic [OFFSET_W-1:0] offset);
    return {tile, 1'b0, region, offset};
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    error_count++;
  endtask

  `include "tb_mpsoc_tasks.svh"

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    req           = 1'b0;
    we            = 1'b0;
    addr.raw      = '0;
    wdata         = '0;
    sel           = '0;
    rst           = 1'b1;
    lfsr_state    = 32'd61;
    error_count   = 0;
    timeout_count = 0;
    repeat (4) @(negedge wb_clk);
    rst = 1'b0;

    test_reset();
    test_ram_isolation();
    test_byte_select();
    test_mailbox();
    test_decode_error();
    test_pipeline();

    $display("Errors: %0d, timeouts: %0d", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+tests
rtl/mpsoc_pkg.sv
rtl/mpsoc_dbg_dispatch.sv
rtl/mpsoc_tile_ram.sv
rtl/mpsoc_tile_mailbox.sv
rtl/mpsoc_tile.sv
rtl/mpsoc_resp_collect.sv
rtl/mpsoc_top.sv
tests/tb_mpsoc.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mpsoc
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG) || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
